/* Bender.yml */
package:
  name: skin_detect

sources:
  - files:
      - hdl/video_pkg.sv
      - hdl/delay_line.sv
      - hdl/rgb_to_ycbcr.sv
      - hdl/skin_cfg_regs.sv
      - hdl/bin_face.sv
      - hdl/skin_stats.sv
      - hdl/skin_detect_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_skin_detect.sv

/* flist.f */
+incdir+tests
hdl/video_pkg.sv
hdl/delay_line.sv
hdl/rgb_to_ycbcr.sv
hdl/skin_cfg_regs.sv
hdl/bin_face.sv
hdl/skin_stats.sv
hdl/skin_detect_top.sv
tests/tb_skin_detect.sv

/* hdl/bin_face.sv */
`timescale 1ns/10ps

module bin_face #(
    parameter int H_ACT = video_pkg::H_ACT_DEF,
    parameter int V_ACT = video_pkg::V_ACT_DEF
) (
    input  logic                                          clk,
    input  logic                                          i_rst,
    input  logic                                          i_en,
    input  logic [7:0]                                    i_cb_lb,
    input  logic [7:0]                                    i_cb_hb,
    input  logic [7:0]                                    i_cr_lb,
    input  logic [7:0]                                    i_cr_hb,
    input  logic [video_pkg::pack_width(H_ACT, V_ACT)-1:0] i_pack,
    output logic [video_pkg::pack_width(H_ACT, V_ACT)-1:0] o_pack,
    output logic                                          o_skin,
    output logic                                          o_vsync,
    output logic                                          o_de
);

    import video_pkg::*;

    localparam int PW = pack_width(H_ACT, V_ACT);
    localparam int XW = $clog2(H_ACT);
    localparam int YW = $clog2(V_ACT);

    logic [7:0]    r;
    logic [7:0]    g;
    logic [7:0]    b;
    logic [7:0]    cb;
    logic [7:0]    cr;
    logic          skin;
    logic [7:0]    bin;

    logic [PW-1:0] d_pack;
    logic          d_hsync;
    logic          d_vsync;
    logic          d_de;
    logic [7:0]    d_r;
    logic [7:0]    d_g;
    logic [7:0]    d_b;
    logic [XW-1:0] d_x;
    logic [YW-1:0] d_y;

    assign {r, g, b} = i_pack[XW+YW +: 24];

    rgb_to_ycbcr u_rgb_to_ycbcr (
        .clk  (clk),
        .i_rst(i_rst),
        .i_r  (r),
        .i_g  (g),
        .i_b  (b),
        .o_y  (),
        .o_cb (cb),
        .o_cr (cr)
    );

    // whole word rides alongside the conversion.
    delay_line #(
        .DELAY(YCBCR_LAT),
        .WIDTH(PW)
    ) u_delay_line (
        .clk   (clk),
        .i_rst (i_rst),
        .i_data(i_pack),
        .o_data(d_pack)
    );

    assign {d_hsync, d_vsync, d_de, d_r, d_g, d_b, d_x, d_y} = d_pack;

    assign skin = (cb >= i_cb_lb) && (cb <= i_cb_hb)
               && (cr >= i_cr_lb) && (cr <= i_cr_hb);  // inclusive window.
    assign bin  = skin ? 8'hFF : 8'h00;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_pack <= '0;
            o_skin <= 1'b0;
        end else begin
            if (i_en)
                o_pack <= {d_hsync, d_vsync, d_de, bin, bin, bin, d_x, d_y};
            else
                o_pack <= {d_hsync, d_vsync, d_de, d_r, d_g, d_b, d_x, d_y};
            o_skin <= skin;
        end
    end

    assign o_vsync = o_pack[PW-2];
    assign o_de    = o_pack[PW-3];

    a_pack_known: assert property (@(posedge clk) disable iff (i_rst)
        !$isunknown(o_pack))
        else $error("o_pack has unknown bits");

    // sync bits leave exactly BIN_LAT cycles after entry.
    a_sync_latency: assert property (@(posedge clk) disable iff (i_rst)
        !$past(i_rst, BIN_LAT) |-> o_pack[PW-1 -: 3] == $past(i_pack[PW-1 -: 3], BIN_LAT))
        else $error("sync misaligned at output");

endmodule : bin_face

/* hdl/delay_line.sv */
`timescale 1ns/10ps

module delay_line #(
    parameter int DELAY = 4,
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             i_rst,
    input  logic [WIDTH-1:0] i_data,
    output logic [WIDTH-1:0] o_data
);

    logic [WIDTH-1:0] taps [DELAY];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < DELAY; i++) begin
                taps[i] <= '0;
            end
        end else begin
            taps[0] <= i_data;
            for (int i = 1; i < DELAY; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    assign o_data = taps[DELAY-1];  // oldest entry.

    initial begin
        assert (DELAY >= 1)
            else $error("delay_line needs at least one stage");
    end

endmodule : delay_line

/* hdl/rgb_to_ycbcr.sv */
`timescale 1ns/10ps

module rgb_to_ycbcr (
    input  logic       clk,
    input  logic       i_rst,
    input  logic [7:0] i_r,
    input  logic [7:0] i_g,
    input  logic [7:0] i_b,
    output logic [7:0] o_y,
    output logic [7:0] o_cb,
    output logic [7:0] o_cr
);

    logic [15:0] p_y_r, p_y_g, p_y_b;
    logic [15:0] p_cb_r, p_cb_g, p_cb_b;
    logic [15:0] p_cr_r, p_cr_g, p_cr_b;

    logic        [17:0] s_y;
    logic signed [17:0] s_cb;
    logic signed [17:0] s_cr;

    logic signed [17:0] y_t;
    logic signed [17:0] cb_t;
    logic signed [17:0] cr_t;

    function automatic logic [7:0] clamp8(input logic signed [17:0] v);
        if (v < 0)
            return 8'd0;
        else if (v > 18'sd255)
            return 8'd255;
        else
            return v[7:0];
    endfunction

    // arithmetic shift floors toward minus infinity.
    assign y_t  = $signed(s_y >> 8);
    assign cb_t = (s_cb >>> 8) + 18'sd128;
    assign cr_t = (s_cr >>> 8) + 18'sd128;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            {p_y_r, p_y_g, p_y_b}    <= '0;
            {p_cb_r, p_cb_g, p_cb_b} <= '0;
            {p_cr_r, p_cr_g, p_cr_b} <= '0;
            s_y  <= '0;
            s_cb <= '0;
            s_cr <= '0;
            o_y  <= '0;
            o_cb <= '0;
            o_cr <= '0;
        end else begin
            p_y_r  <= 16'd77 * i_r;  // stage 1, products.
            p_y_g  <= 16'd150 * i_g;
            p_y_b  <= 16'd29 * i_b;
            p_cb_r <= 16'd43 * i_r;
            p_cb_g <= 16'd85 * i_g;
            p_cb_b <= 16'd128 * i_b;
            p_cr_r <= 16'd128 * i_r;
            p_cr_g <= 16'd107 * i_g;
            p_cr_b <= 16'd21 * i_b;
            s_y  <= {2'b00, p_y_r} + {2'b00, p_y_g} + {2'b00, p_y_b};  // stage 2, sums.
            s_cb <= $signed({2'b00, p_cb_b}) - $signed({2'b00, p_cb_r})
                    - $signed({2'b00, p_cb_g});
            s_cr <= $signed({2'b00, p_cr_r}) - $signed({2'b00, p_cr_g})
                    - $signed({2'b00, p_cr_b});
            o_y  <= clamp8(y_t);  // stage 3, shift and clamp.
            o_cb <= clamp8(cb_t);
            o_cr <= clamp8(cr_t);
        end
    end

endmodule : rgb_to_ycbcr

/* hdl/skin_cfg_regs.sv */
`timescale 1ns/10ps

module skin_cfg_regs (
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic                         i_cfg_req,
    input  logic                         i_cfg_we,
    input  video_pkg::cfg_addr_e         i_cfg_addr,
    input  logic [video_pkg::CFG_DW-1:0] i_cfg_wdata,
    input  logic [31:0]                  i_skin_cnt,
    output logic                         o_cfg_ack,
    output logic [video_pkg::CFG_DW-1:0] o_cfg_rdata,
    output logic [7:0]                   o_cb_lb,
    output logic [7:0]                   o_cb_hb,
    output logic [7:0]                   o_cr_lb,
    output logic [7:0]                   o_cr_hb,
    output logic                         o_en
);

    import video_pkg::*;

    cfg_state_e          state;
    logic                access;
    logic [CFG_DW-1:0]   rd_mux;

    assign access    = (state == IDLE) && i_cfg_req;  // one access per handshake.
    assign o_cfg_ack = (state == ACK) || (state == WAIT_DROP);

    always_comb begin
        case (i_cfg_addr)
            CB_LB:    rd_mux = {8'h00, o_cb_lb};
            CB_HB:    rd_mux = {8'h00, o_cb_hb};
            CR_LB:    rd_mux = {8'h00, o_cr_lb};
            CR_HB:    rd_mux = {8'h00, o_cr_hb};
            CTRL:     rd_mux = {{(CFG_DW-1){1'b0}}, o_en};
            SKIN_CNT: rd_mux = i_skin_cnt[CFG_DW-1:0];  // low half only.
            default:  rd_mux = '0;  // 6 and 7 unmapped.
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state   <= IDLE;
            o_cb_lb <= CB_LB_DEF;
            o_cb_hb <= CB_HB_DEF;
            o_cr_lb <= CR_LB_DEF;
            o_cr_hb <= CR_HB_DEF;
            o_en    <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (i_cfg_req) begin
                        state <= ACK;
                    end
                end
                ACK: begin
                    state <= i_cfg_req ? WAIT_DROP : IDLE;
                end
                WAIT_DROP: begin
                    if (!i_cfg_req) begin
                        state <= IDLE;  // ack falls next cycle.
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
            if (access && i_cfg_we) begin
                case (i_cfg_addr)
                    CB_LB:   o_cb_lb <= i_cfg_wdata[7:0];
                    CB_HB:   o_cb_hb <= i_cfg_wdata[7:0];
                    CR_LB:   o_cr_lb <= i_cfg_wdata[7:0];
                    CR_HB:   o_cr_hb <= i_cfg_wdata[7:0];
                    CTRL:    o_en    <= i_cfg_wdata[0];
                    default: o_en    <= o_en;  // count is read only.
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && !i_cfg_we) begin
            o_cfg_rdata <= rd_mux;  // valid with ack.
        end
    end

    // no ack without a pending request.
    a_ack_needs_req: assert property (@(posedge clk) disable iff (i_rst)
        !i_cfg_req && !o_cfg_ack |=> !o_cfg_ack)
        else $error("ack raised without req");

    // master holds the address until acknowledged.
    a_addr_stable: assert property (@(posedge clk) disable iff (i_rst)
        i_cfg_req && !o_cfg_ack |=> $stable(i_cfg_addr))
        else $error("cfg address changed before ack");

endmodule : skin_cfg_regs

/* hdl/skin_detect_top.sv */
`timescale 1ns/10ps

module skin_detect_top #(
    parameter int H_ACT = video_pkg::H_ACT_DEF,
    parameter int V_ACT = video_pkg::V_ACT_DEF
) (
    input  logic                                          clk,
    input  logic                                          i_rst,
    input  logic [video_pkg::pack_width(H_ACT, V_ACT)-1:0] i_pack,
    input  logic                                          i_cfg_req,
    input  logic                                          i_cfg_we,
    input  video_pkg::cfg_addr_e                          i_cfg_addr,
    input  logic [video_pkg::CFG_DW-1:0]                  i_cfg_wdata,
    output logic [video_pkg::pack_width(H_ACT, V_ACT)-1:0] o_pack,
    output logic                                          o_cfg_ack,
    output logic [video_pkg::CFG_DW-1:0]                  o_cfg_rdata
);

    logic [7:0]  cb_lb;
    logic [7:0]  cb_hb;
    logic [7:0]  cr_lb;
    logic [7:0]  cr_hb;
    logic        en;
    logic        skin;
    logic        vsync;
    logic        de;
    logic [31:0] skin_cnt;

    skin_cfg_regs u_skin_cfg_regs (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_cfg_req  (i_cfg_req),
        .i_cfg_we   (i_cfg_we),
        .i_cfg_addr (i_cfg_addr),
        .i_cfg_wdata(i_cfg_wdata),
        .i_skin_cnt (skin_cnt),
        .o_cfg_ack  (o_cfg_ack),
        .o_cfg_rdata(o_cfg_rdata),
        .o_cb_lb    (cb_lb),
        .o_cb_hb    (cb_hb),
        .o_cr_lb    (cr_lb),
        .o_cr_hb    (cr_hb),
        .o_en       (en)
    );

    bin_face #(
        .H_ACT(H_ACT),
        .V_ACT(V_ACT)
    ) u_bin_face (
        .clk    (clk),
        .i_rst  (i_rst),
        .i_en   (en),
        .i_cb_lb(cb_lb),
        .i_cb_hb(cb_hb),
        .i_cr_lb(cr_lb),
        .i_cr_hb(cr_hb),
        .i_pack (i_pack),
        .o_pack (o_pack),
        .o_skin (skin),
        .o_vsync(vsync),
        .o_de   (de)
    );

    skin_stats #(
        .H_ACT(H_ACT),
        .V_ACT(V_ACT)
    ) u_skin_stats (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_skin    (skin),
        .i_vsync   (vsync),
        .i_de      (de),
        .o_skin_cnt(skin_cnt)
    );

endmodule : skin_detect_top

/* hdl/skin_stats.sv */
`timescale 1ns/10ps

module skin_stats #(
    parameter int H_ACT = video_pkg::H_ACT_DEF,
    parameter int V_ACT = video_pkg::V_ACT_DEF
) (
    input  logic        clk,
    input  logic        i_rst,
    input  logic        i_skin,
    input  logic        i_vsync,
    input  logic        i_de,
    output logic [31:0] o_skin_cnt
);

    localparam int CNT_W = $clog2(H_ACT * V_ACT + 1);  // full frame of skin.

    logic             vsync_q;
    logic             frame_start;
    logic             hit;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] held;

    assign frame_start = i_vsync && !vsync_q;
    assign hit         = i_skin && i_de;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            vsync_q <= 1'b0;
            cnt     <= '0;
            held    <= '0;
        end else begin
            vsync_q <= i_vsync;
            if (frame_start) begin
                held <= cnt;
                cnt  <= hit ? CNT_W'(1) : '0;
            end else if (hit) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign o_skin_cnt = 32'(held);

endmodule : skin_stats

/* hdl/video_pkg.sv */
package video_pkg;

    // default frame geometry.
    localparam int H_ACT_DEF = 1280;
    localparam int V_ACT_DEF = 720;

    // configuration port widths.
    localparam int CFG_AW = 3;
    localparam int CFG_DW = 16;

    typedef enum logic [CFG_AW-1:0] {
        CB_LB    = 3'd0,
        CB_HB    = 3'd1,
        CR_LB    = 3'd2,
        CR_HB    = 3'd3,
        CTRL     = 3'd4,  // bit 0 is the enable.
        SKIN_CNT = 3'd5   // read only.
    } cfg_addr_e;

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_DROP
    } cfg_state_e;

    // chroma window after reset.
    localparam logic [7:0] CB_LB_DEF = 8'd77;
    localparam logic [7:0] CB_HB_DEF = 8'd127;
    localparam logic [7:0] CR_LB_DEF = 8'd133;
    localparam logic [7:0] CR_HB_DEF = 8'd173;

    localparam int YCBCR_LAT = 3;  // colour conversion depth.
    localparam int BIN_LAT   = 4;  // pixel word in to out.

    // word layout, msb first: hsync, vsync, de, r, g, b, x, y.
    function automatic int pack_width(input int h_act, input int v_act);
        int xw;
        int yw;
        xw = $clog2(h_act);
        yw = $clog2(v_act);
        return 3 + 3 * 8 + xw + yw;
    endfunction

endpackage : video_pkg

/* tests/tb_skin_tasks.svh */
`ifndef TB_SKIN_TASKS_SVH
`define TB_SKIN_TASKS_SVH

task automatic check_pack(input logic [PW-1:0] got, input logic [PW-1:0] exp, input string msg);
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
    end
endtask

task automatic check_cfg(input logic [CFG_DW-1:0] got, input logic [CFG_DW-1:0] exp,
                         input string msg);
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
    end
endtask

task automatic drive_pixel(input logic [PW-1:0] word, input logic chk);
    @(posedge clk);
    i_pack   <= word;
    check_on <= chk;  // model compares this word on exit.
endtask

task automatic flush();
    repeat (BIN_LAT + 1) drive_pixel('0, 1'b0);
endtask

task automatic wait_ack(input logic level, input string what);
    int n;
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while (o_cfg_ack !== level && n < TIMEOUT);
    if (o_cfg_ack !== level) begin
        errors++;
        $display("timeout at %0t ns: ack never went to %b during %s", $time, level, what);
    end
endtask

task automatic cfg_write(input cfg_addr_e addr, input logic [CFG_DW-1:0] data);
    @(posedge clk);
    i_cfg_req   <= 1'b1;
    i_cfg_we    <= 1'b1;
    i_cfg_addr  <= addr;
    i_cfg_wdata <= data;
    wait_ack(1'b1, "write");
    @(posedge clk);
    i_cfg_req <= 1'b0;
    wait_ack(1'b0, "write release");
    case (addr)
        CB_LB:   cb_lb_m = data[7:0];
        CB_HB:   cb_hb_m = data[7:0];
        CR_LB:   cr_lb_m = data[7:0];
        CR_HB:   cr_hb_m = data[7:0];
        CTRL:    en_m = data[0];
        default: en_m = en_m;
    endcase
endtask

task automatic cfg_read(input cfg_addr_e addr, output logic [CFG_DW-1:0] data);
    @(posedge clk);
    i_cfg_req  <= 1'b1;
    i_cfg_we   <= 1'b0;
    i_cfg_addr <= addr;
    wait_ack(1'b1, "read");
    data = o_cfg_rdata;  // valid with ack.
    @(posedge clk);
    i_cfg_req <= 1'b0;
    wait_ack(1'b0, "read release");
endtask

`endif

/* tests/tb_skin_detect.sv */
`timescale 1ns/10ps

module tb_skin_detect;

    import video_pkg::*;

    localparam int H_ACT   = 1280;
    localparam int V_ACT   = 720;
    localparam int PW      = pack_width(H_ACT, V_ACT);
    localparam int XW      = $clog2(H_ACT);
    localparam int YW      = $clog2(V_ACT);
    localparam int TIMEOUT = 20;

    logic              clk;
    logic              i_rst;
    logic [PW-1:0]     i_pack;
    logic              i_cfg_req;
    logic              i_cfg_we;
    cfg_addr_e         i_cfg_addr;
    logic [CFG_DW-1:0] i_cfg_wdata;
    logic [PW-1:0]     o_pack;
    logic              o_cfg_ack;
    logic [CFG_DW-1:0] o_cfg_rdata;

    logic              check_on;
    logic [7:0]        cb_lb_m;
    logic [7:0]        cb_hb_m;
    logic [7:0]        cr_lb_m;
    logic [7:0]        cr_hb_m;
    logic              en_m;
    logic [PW:0]       exp_q[$];  // check flag over expected word.
    int                errors;
    int                n_pass;
    int                n_fail;
    int                seed;

    skin_detect_top #(
        .H_ACT(H_ACT),
        .V_ACT(V_ACT)
    ) i_skin_detect_top (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_pack     (i_pack),
        .i_cfg_req  (i_cfg_req),
        .i_cfg_we   (i_cfg_we),
        .i_cfg_addr (i_cfg_addr),
        .i_cfg_wdata(i_cfg_wdata),
        .o_pack     (o_pack),
        .o_cfg_ack  (o_cfg_ack),
        .o_cfg_rdata(o_cfg_rdata)
    );

    function automatic int clamp(input int v);
        if (v < 0)
            return 0;
        if (v > 255)
            return 255;
        return v;
    endfunction

    // floor shift, then offset by 128.
    function automatic int to_cb(input int r, input int g, input int b);
        return clamp(128 + ((-43 * r - 85 * g + 128 * b) >>> 8));
    endfunction

    function automatic int to_cr(input int r, input int g, input int b);
        return clamp(128 + ((128 * r - 107 * g - 21 * b) >>> 8));
    endfunction

    function automatic logic is_skin(input int r, input int g, input int b);
        int cb;
        int cr;
        cb = to_cb(r, g, b);
        cr = to_cr(r, g, b);
        return cb >= cb_lb_m && cb <= cb_hb_m && cr >= cr_lb_m && cr <= cr_hb_m;
    endfunction

    function automatic logic near_edge(input int v, input int lb, input int hb);
        return (v >= lb - 1 && v <= lb + 1) || (v >= hb - 1 && v <= hb + 1);
    endfunction

    function automatic logic [PW-1:0] make_word(input logic [2:0] sync, input logic [23:0] rgb,
                                                input int x, input int y);
        return {sync, rgb, x[XW-1:0], y[YW-1:0]};
    endfunction

    function automatic logic [PW-1:0] expected_word(input logic [PW-1:0] w);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic [7:0] v;
        {r, g, b} = w[XW+YW +: 24];
        if (!en_m)
            return w;
        v = is_skin(r, g, b) ? 8'hFF : 8'h00;
        return {w[PW-1 -: 3], v, v, v, w[XW+YW-1:0]};
    endfunction

    `include "tb_skin_tasks.svh"

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // reference pipeline, BIN_LAT entries deep.
    always @(negedge clk) begin : model_check
        logic [PW:0] e;
        exp_q.push_back({check_on, expected_word(i_pack)});
        if (exp_q.size() > BIN_LAT) begin
            e = exp_q.pop_front();
            if (e[PW])
                check_pack(o_pack, e[PW-1:0], "o_pack vs model");
        end
    end

    task automatic end_test(input string name, input int err0);
        if (errors == err0) begin
            n_pass++;
            $display("PASS  %s", name);
        end else begin
            n_fail++;
            $display("FAIL  %s", name);
        end
    endtask

    task automatic send_random(input int n);
        logic [31:0] rnd;
        for (int i = 0; i < n; i++) begin
            rnd = $random(seed);
            drive_pixel(make_word(rnd[26:24], rnd[23:0], i, i % V_ACT), 1'b1);
        end
        flush();
    endtask

    task automatic send_edges();
        int cb;
        int cr;
        for (int r = 150; r <= 250; r += 50) begin
            for (int b = 0; b < 256; b++) begin
                cb = to_cb(r, 120, b);
                cr = to_cr(r, 120, b);
                if (near_edge(cb, cb_lb_m, cb_hb_m) || near_edge(cr, cr_lb_m, cr_hb_m))
                    drive_pixel(make_word(3'b001, {8'(r), 8'd120, 8'(b)}, b, r), 1'b1);
            end
        end
        flush();
    endtask

    task automatic test_reset();
        int e0;
        logic [CFG_DW-1:0] v;
        e0 = errors;
        @(negedge clk);
        check_pack(o_pack, '0, "o_pack after reset");
        check_flag(o_cfg_ack, 1'b0, "ack after reset");
        cfg_read(CB_LB, v);
        check_cfg(v, 16'd77, "CB_LB default");
        cfg_read(CB_HB, v);
        check_cfg(v, 16'd127, "CB_HB default");
        cfg_read(CR_LB, v);
        check_cfg(v, 16'd133, "CR_LB default");
        cfg_read(CR_HB, v);
        check_cfg(v, 16'd173, "CR_HB default");
        cfg_read(CTRL, v);
        check_cfg(v, 16'd1, "CTRL default");
        end_test("reset defaults", e0);
    endtask

    task automatic test_enabled();
        int e0;
        e0 = errors;
        send_random(200);
        send_edges();
        end_test("binarise with default window", e0);
    endtask

    task automatic test_bypass();
        int e0;
        e0 = errors;
        cfg_write(CTRL, 16'd0);
        send_random(100);
        cfg_write(CTRL, 16'd1);
        end_test("pass-through when disabled", e0);
    endtask

    task automatic test_bounds();
        int e0;
        logic [CFG_DW-1:0] v;
        e0 = errors;
        cfg_write(CB_LB, 16'd90);
        cfg_write(CB_HB, 16'd140);
        cfg_write(CR_LB, 16'd120);
        cfg_write(CR_HB, 16'd160);
        cfg_read(CB_LB, v);
        check_cfg(v, 16'd90, "CB_LB read-back");
        cfg_read(CB_HB, v);
        check_cfg(v, 16'd140, "CB_HB read-back");
        cfg_read(CR_LB, v);
        check_cfg(v, 16'd120, "CR_LB read-back");
        cfg_read(CR_HB, v);
        check_cfg(v, 16'd160, "CR_HB read-back");
        send_random(100);
        send_edges();
        end_test("new window", e0);
    endtask

    task automatic test_stats();
        int e0;
        int cnt;
        logic de;
        logic [23:0] rgb;
        logic [CFG_DW-1:0] v;
        e0 = errors;
        cnt = 0;
        drive_pixel(make_word(3'b010, 24'h0, 0, 0), 1'b1);  // opens the frame.
        drive_pixel(make_word(3'b000, 24'h0, 0, 0), 1'b1);
        for (int i = 0; i < 64; i++) begin
            rgb = {8'(150 + i), 8'd120, 8'(i * 4)};
            de  = (i % 8 != 7);
            if (de && is_skin(rgb[23:16], rgb[15:8], rgb[7:0]))
                cnt++;
            drive_pixel(make_word({2'b00, de}, rgb, i, 1), 1'b1);
        end
        drive_pixel(make_word(3'b010, 24'h0, 0, 0), 1'b1);  // latches the count.
        flush();
        cfg_read(SKIN_CNT, v);
        check_cfg(v, cnt[15:0], "SKIN_CNT after frame");
        end_test("skin count per frame", e0);
    endtask

    task automatic test_hold();
        int e0;
        int rises;
        logic prev;
        e0 = errors;
        rises = 0;
        prev = 1'b0;
        @(posedge clk);
        i_cfg_req  <= 1'b1;
        i_cfg_we   <= 1'b0;
        i_cfg_addr <= CTRL;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (o_cfg_ack && !prev)
                rises++;
            prev = o_cfg_ack;
        end
        check_flag(rises == 1, 1'b1, "single ack rise while req held");
        @(posedge clk);
        i_cfg_req <= 1'b0;
        @(negedge clk);
        check_flag(o_cfg_ack, 1'b1, "ack still high as req drops");
        wait_ack(1'b0, "held request release");
        end_test("held request", e0);
    endtask

    initial begin
        seed        = 33958;
        errors      = 0;
        n_pass      = 0;
        n_fail      = 0;
        i_rst       = 1'b1;
        i_pack      = '1;
        i_cfg_req   = 1'b0;
        i_cfg_we    = 1'b0;
        i_cfg_addr  = CB_LB;
        i_cfg_wdata = '0;
        check_on    = 1'b0;
        cb_lb_m     = 8'd77;
        cb_hb_m     = 8'd127;
        cr_lb_m     = 8'd133;
        cr_hb_m     = 8'd173;
        en_m        = 1'b1;
        repeat (10) @(posedge clk);
        i_rst  <= 1'b0;
        i_pack <= '0;
        test_reset();
        test_enabled();
        test_bypass();
        test_bounds();
        test_stats();
        test_hold();
        $display("summary: %0d passed, %0d failed, %0d check errors", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : tb_skin_detect
